// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ep0Tb
RTL_TOP ?= ep0Top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/ep0Tasks.svh ====
task automatic noteTimeout(input string what);
    timeoutCount++;
    $display("Timeout while waiting for %s", what);
endtask

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    checkCount++;
    assert (got === want) else begin
        errorCount++;
        $display("error %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
endtask

task automatic checkFlag(input bit cond, input string what);
    checkCount++;
    assert (cond) else begin
        errorCount++;
        $display("%s", what);
    end
endtask

function automatic setupPacket_t makeSetup(input logic [7:0] reqType, input logic [7:0] req,
                                           input logic [15:0] value, input logic [15:0] index,
                                           input logic [15:0] length);
    setupPacket_t pkt;
    pkt.bmRequestType = reqType;
    pkt.bRequest = req;
    pkt.wValue = value;
    pkt.wIndex = index;
    pkt.wLength = length;
    return pkt;
endfunction

// Type in the high byte of wValue and language in wIndex for real strings
function automatic setupPacket_t descriptorRequest(input logic [7:0] descType,
                                                   input logic [7:0] descIndex,
                                                   input logic [15:0] length);
    logic [15:0] lang;
    lang = (descType == DESC_STRING && descIndex != 8'd0) ? LANG_ID : 16'd0;
    return makeSetup(8'h80, REQ_GET_DESCRIPTOR, {descType, descIndex}, lang, length);
endfunction

// All driving tasks start and end 2 ns after a rising edge
task automatic sendSetup(input setupPacket_t pkt);
    int cycles;
    bit accepted;
    setupValid = 1'b1;
    setup = pkt;
    accepted = 1'b0;
    for (cycles = 0; cycles < WAIT_LIMIT && !accepted; cycles++) begin
        @(negedge clk);
        accepted = setupReady;
        @(posedge clk);
        #2;
    end
    setupValid = 1'b0;
    if (!accepted) noteTimeout("setupReady");
endtask

// Samples at the falling edge where every DUT output is settled
task automatic collectResponse(input bit useRandom);
    int cycles;
    bit held;
    romByte_t heldData;
    received.delete();
    doneSeen = 1'b0;
    stallSeen = 1'b0;
    lastCount = 0;
    lastIndex = -1;
    validCount = 0;
    held = 1'b0;
    heldData = '0;
    for (cycles = 0; cycles < WAIT_LIMIT && !doneSeen; cycles++) begin
        txReady = useRandom ? 1'($random(seed)) : 1'b1;
        @(negedge clk);
        // A stalled beat must stay on the bus unchanged
        if (held) begin
            checkFlag(txValid, "txValid dropped while txReady was low");
            checkValue("txData under back-pressure", 32'(txData), 32'(heldData));
        end
        held = txValid && !txReady;
        heldData = txData;
        if (txValid) validCount++;
        if (txValid && txReady) begin
            received.push_back(txData);
            if (txLast) begin
                lastCount++;
                lastIndex = received.size() - 1;
            end
        end
        if (reqDone) begin
            doneSeen = 1'b1;
            stallSeen = reqStall;
        end
        @(posedge clk);
        #2;
    end
    txReady = 1'b0;
    if (!doneSeen) noteTimeout("reqDone");
endtask

task automatic runRequest(input setupPacket_t pkt, input bit useRandom);
    sendSetup(pkt);
    collectResponse(useRandom);
endtask

task automatic apbWrite(input apbAddr_t addr, input apbData_t data);
    int cycles;
    bit ready;
    bit err;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    ready = 1'b0;
    err = 1'b0;
    for (cycles = 0; cycles < WAIT_LIMIT && !ready; cycles++) begin
        @(negedge clk);
        ready = pready;
        err = pslverr;
        @(posedge clk);
        #2;
    end
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    if (!ready) noteTimeout("pready on a write");
    checkValue($sformatf("pslverr on write to 0x%0h", addr), 32'(err), 32'h0);
endtask

task automatic apbRead(input apbAddr_t addr, output apbData_t data, output logic err);
    int cycles;
    bit ready;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    ready = 1'b0;
    data = '0;
    err = 1'b0;
    for (cycles = 0; cycles < WAIT_LIMIT && !ready; cycles++) begin
        @(negedge clk);
        ready = pready;
        data = prdata;
        err = pslverr;
        @(posedge clk);
        #2;
    end
    psel = 1'b0;
    penable = 1'b0;
    if (!ready) noteTimeout("pready on a read");
endtask

task automatic expectRegister(input apbAddr_t addr, input apbData_t want, input string name);
    apbData_t data;
    logic err;
    apbRead(addr, data, err);
    checkValue(name, data, want);
    checkValue({name, " pslverr"}, 32'(err), 32'h0);
endtask

task automatic expectData(input int len, input string what);
    checkFlag(!stallSeen, {what, " was stalled instead of answered"});
    checkValue({what, " byte count"}, 32'(received.size()), 32'(len));
    checkValue({what, " txLast count"}, 32'(lastCount), 32'h1);
    checkValue({what, " txLast position"}, 32'(lastIndex), 32'(len - 1));
endtask

task automatic compareBytes(input string what);
    int count;
    count = (received.size() < expected.size()) ? received.size() : expected.size();
    for (int i = 0; i < count; i++) begin
        checkValue($sformatf("%s txData[%0d]", what, i), 32'(received[i]), 32'(expected[i]));
    end
endtask

task automatic expectStall(input setupPacket_t pkt, input string what);
    runRequest(pkt, 1'b0);
    checkFlag(stallSeen, {what, " finished without reqStall"});
    checkValue({what, " txValid cycles"}, 32'(validCount), 32'h0);
    stallsSent++;
endtask

task automatic afterReset();
    @(negedge clk);
    checkValue("setupReady in first cycle", 32'(setupReady), 32'h0);
    checkValue("txValid after reset", 32'(txValid), 32'h0);
    checkValue("reqDone after reset", 32'(reqDone), 32'h0);
    checkValue("reqStall after reset", 32'(reqStall), 32'h0);
    checkValue("pslverr after reset", 32'(pslverr), 32'h0);
    @(posedge clk);
    #2;
    @(negedge clk);
    checkValue("setupReady in second cycle", 32'(setupReady), 32'h1);
    @(posedge clk);
    #2;
    expectRegister(REG_CTRL, 32'h0, "REG_CTRL after reset");
    expectRegister(REG_ADDR, 32'h0, "REG_ADDR after reset");
    expectRegister(REG_CONF, 32'h0, "REG_CONF after reset");
    expectRegister(REG_STALLS, 32'h0, "REG_STALLS after reset");
endtask

task automatic deviceDescriptor();
    apbWrite(REG_CTRL, 32'h1);
    expectRegister(REG_CTRL, 32'h1, "REG_CTRL");
    // Host asks for more than the descriptor holds
    runRequest(descriptorRequest(DESC_DEVICE, 8'd0, 16'd64), 1'b1);
    expectData(DEVICE_DESC_LEN, "device descriptor");
    if (received.size() >= 8) begin
        checkValue("device bLength", 32'(received[0]), 32'(DEVICE_DESC_LEN));
        checkValue("device bDescriptorType", 32'(received[1]), 32'(DESC_DEVICE));
        checkValue("device bMaxPacketSize0", 32'(received[7]), 32'(MAX_PACKET0));
    end
endtask

task automatic headerAt(input int offset, input int len, input logic [7:0] descType,
                        input string what);
    checkValue({what, " bLength"}, 32'(received[offset]), 32'(len));
    checkValue({what, " bDescriptorType"}, 32'(received[offset + 1]), 32'(descType));
endtask

task automatic configBlock();
    runRequest(descriptorRequest(DESC_CONFIG, 8'd0, 16'd9), 1'b0);
    expectData(CONFIG_DESC_LEN, "configuration wLength 9");
    if (received.size() == CONFIG_DESC_LEN) begin
        headerAt(0, CONFIG_DESC_LEN, DESC_CONFIG, "short configuration");
    end
    runRequest(descriptorRequest(DESC_CONFIG, 8'd0, 16'd255), 1'b1);
    expectData(CONFIG_TOTAL_LEN, "configuration block");
    if (received.size() == CONFIG_TOTAL_LEN) begin
        headerAt(0, CONFIG_DESC_LEN, DESC_CONFIG, "configuration");
        checkValue("wTotalLength low", 32'(received[2]), 32'(CONFIG_TOTAL_LEN % 256));
        checkValue("wTotalLength high", 32'(received[3]), 32'(CONFIG_TOTAL_LEN / 256));
        headerAt(CONFIG_DESC_LEN, IFACE_DESC_LEN, DESC_INTERFACE, "interface");
        headerAt(CONFIG_DESC_LEN + IFACE_DESC_LEN, EP_DESC_LEN, DESC_ENDPOINT, "endpoint");
    end
endtask

task automatic stringDescriptors();
    string text;
    expected.delete();
    expected.push_back(romByte_t'(STRING0_LEN));
    expected.push_back(DESC_STRING);
    expected.push_back(LANG_ID[7:0]);
    expected.push_back(LANG_ID[15:8]);
    runRequest(descriptorRequest(DESC_STRING, 8'd0, 16'd255), 1'b0);
    expectData(STRING0_LEN, "string 0");
    compareBytes("string 0");

    // ASCII widened to UTF-16LE in reading order of the text
    text = $sformatf("%s", PRODUCT_STR);
    expected.delete();
    expected.push_back(romByte_t'(PRODUCT_STR_LEN));
    expected.push_back(DESC_STRING);
    for (int i = 0; i < text.len(); i++) begin
        expected.push_back(romByte_t'(text[i]));
        expected.push_back(8'h00);
    end
    runRequest(descriptorRequest(DESC_STRING, 8'd1, 16'd255), 1'b1);
    expectData(PRODUCT_STR_LEN, "string 1");
    compareBytes("string 1");
endtask

task automatic setRequests();
    runRequest(makeSetup(8'h00, REQ_SET_ADDRESS, 16'h002A, 16'd0, 16'd0), 1'b0);
    checkFlag(!stallSeen, "SET_ADDRESS was stalled");
    checkValue("SET_ADDRESS txValid cycles", 32'(validCount), 32'h0);
    expectRegister(REG_ADDR, 32'h2A, "REG_ADDR");

    runRequest(makeSetup(8'h00, REQ_SET_CONFIGURATION, 16'd1, 16'd0, 16'd0), 1'b0);
    checkFlag(!stallSeen, "SET_CONFIGURATION was stalled");
    checkValue("SET_CONFIGURATION txValid cycles", 32'(validCount), 32'h0);
    expectRegister(REG_CONF, 32'h1, "REG_CONF");
endtask

task automatic stallCases();
    apbData_t data;
    logic err;
    apbWrite(REG_STALLS, 32'h0);
    stallsSent = 0;
    expectStall(makeSetup(8'h80, 8'h33, 16'd0, 16'd0, 16'd8), "unknown request");
    expectStall(makeSetup(8'h00, REQ_SET_CONFIGURATION, 16'd3, 16'd0, 16'd0),
                "SET_CONFIGURATION 3");
    expectStall(descriptorRequest(DESC_STRING, 8'd5, 16'd255), "string index 5");
    expectStall(descriptorRequest(DESC_DEVICE, 8'd0, 16'd0), "zero wLength");
    apbWrite(REG_CTRL, 32'h0);
    expectStall(descriptorRequest(DESC_DEVICE, 8'd0, 16'd64), "request while disabled");
    expectRegister(REG_STALLS, 32'(stallsSent), "REG_STALLS");
    apbWrite(REG_STALLS, 32'h1);
    expectRegister(REG_STALLS, 32'h0, "REG_STALLS after clear");
    apbRead(4'h3, data, err);
    checkValue("pslverr at unmapped 0x3", 32'(err), 32'h1);
endtask

// ==== bench/ep0Tb.sv ====
`timescale 1ns/1ps

module ep0Tb
    import usbDescPkg::*;
    import ep0Pkg::*;
();

    // Upper bound on every wait loop, in clock cycles
    localparam int WAIT_LIMIT = 400;

    logic         clk;
    logic         reset;
    logic         setupValid;
    setupPacket_t setup;
    logic         setupReady;
    logic         txValid;
    romByte_t     txData;
    logic         txLast;
    logic         txReady;
    logic         reqDone;
    logic         reqStall;
    logic         psel;
    logic         penable;
    logic         pwrite;
    apbAddr_t     paddr;
    apbData_t     pwdata;
    apbData_t     prdata;
    logic         pready;
    logic         pslverr;

    integer seed;
    int     checkCount;
    int     errorCount;
    int     timeoutCount;
    int     stallsSent;

    // Result of the last collected request
    romByte_t received[$];
    romByte_t expected[$];
    bit       doneSeen;
    bit       stallSeen;
    int       lastCount;
    int       lastIndex;
    int       validCount;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ep0Top ep0Top_i (
        .clk        (clk),
        .reset      (reset),
        .setupValid (setupValid),
        .setup      (setup),
        .setupReady (setupReady),
        .txValid    (txValid),
        .txData     (txData),
        .txLast     (txLast),
        .txReady    (txReady),
        .reqDone    (reqDone),
        .reqStall   (reqStall),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    `include "ep0Tasks.svh"

    initial begin
        seed = 32'h6aa1_88a2;
        checkCount = 0;
        errorCount = 0;
        timeoutCount = 0;
        stallsSent = 0;
        reset = 1'b1;
        setupValid = 1'b0;
        setup = '0;
        txReady = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        afterReset();
        // A timeout leaves the DUT in an unknown state, so skip the rest
        if (timeoutCount == 0) deviceDescriptor();
        if (timeoutCount == 0) configBlock();
        if (timeoutCount == 0) stringDescriptors();
        if (timeoutCount == 0) setRequests();
        if (timeoutCount == 0) stallCases();

        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== common/ep0Pkg.sv ====
package ep0Pkg;
    import usbDescPkg::*;

    typedef struct packed {
        logic [7:0]  bmRequestType;
        logic [7:0]  bRequest;
        logic [15:0] wValue;
        logic [15:0] wIndex;
        logic [15:0] wLength;
    } setupPacket_t;

    // Standard request codes
    localparam logic [7:0] REQ_SET_ADDRESS = 8'd5;
    localparam logic [7:0] REQ_GET_DESCRIPTOR = 8'd6;
    localparam logic [7:0] REQ_SET_CONFIGURATION = 8'd9;

    typedef logic [6:0] usbAddr_t;
    typedef logic [7:0] confValue_t;
    typedef logic [15:0] stallCount_t;
    // Value field of SET_ADDRESS / SET_CONFIGURATION after range check
    typedef logic [6:0] reqValue_t;

    typedef enum logic [1:0] {
        CMD_SEND,
        CMD_SET_ADDR,
        CMD_SET_CONF,
        CMD_STALL
    } ep0CmdKind_t;

    typedef struct packed {
        ep0CmdKind_t kind;
        lutIdx_t     lutIndex;
        descLen_t    xferLen;
        reqValue_t   value;
    } ep0Cmd_t;

    typedef struct packed {
        logic      setAddr;
        logic      setConf;
        logic      stall;
        reqValue_t value;
    } ep0Event_t;

    // APB register map
    typedef logic [3:0] apbAddr_t;
    typedef logic [31:0] apbData_t;

    localparam apbAddr_t REG_CTRL = 4'h0;
    localparam apbAddr_t REG_ADDR = 4'h4;
    localparam apbAddr_t REG_CONF = 4'h8;
    localparam apbAddr_t REG_STALLS = 4'hC;

endpackage

// ==== common/usbDescPkg.sv ====
package usbDescPkg;

    // Layout of the fixed descriptor set
    localparam int DESC_HEADER_BYTES = 2;
    localparam int DEVICE_DESC_LEN = 18;
    localparam int CONFIG_DESC_LEN = 9;
    localparam int IFACE_DESC_LEN = 9;
    localparam int EP_DESC_LEN = 7;
    localparam int CONFIG_TOTAL_LEN = CONFIG_DESC_LEN + IFACE_DESC_LEN + EP_DESC_LEN;

    localparam logic [15:0] LANG_ID = 16'h0409;
    localparam int STRING0_LEN = DESC_HEADER_BYTES + 2;

    localparam int PRODUCT_STR_CHARS = 4;
    localparam logic [PRODUCT_STR_CHARS*8-1:0] PRODUCT_STR = "FPGA";
    // Each ASCII character becomes one UTF-16LE code unit
    localparam int PRODUCT_STR_LEN = DESC_HEADER_BYTES + 2 * PRODUCT_STR_CHARS;

    localparam int LUT_ENTRIES = 4;
    localparam int ROM_SIZE = LUT_ENTRIES + DEVICE_DESC_LEN + CONFIG_TOTAL_LEN
                              + STRING0_LEN + PRODUCT_STR_LEN;

    typedef logic [$clog2(ROM_SIZE)-1:0] romAddr_t;
    typedef logic [7:0] romByte_t;
    typedef logic [7:0] descLen_t;
    typedef logic [$clog2(LUT_ENTRIES)-1:0] lutIdx_t;
    typedef logic [ROM_SIZE*8-1:0] romImage_t;

    // Lookup table order
    localparam lutIdx_t LUT_DEVICE = 2'd0;
    localparam lutIdx_t LUT_CONFIG = 2'd1;
    localparam lutIdx_t LUT_STRING0 = 2'd2;

    // bDescriptorType codes
    localparam logic [7:0] DESC_DEVICE = 8'd1;
    localparam logic [7:0] DESC_CONFIG = 8'd2;
    localparam logic [7:0] DESC_STRING = 8'd3;
    localparam logic [7:0] DESC_INTERFACE = 8'd4;
    localparam logic [7:0] DESC_ENDPOINT = 8'd5;

    // Fixed device contents
    localparam logic [15:0] USB_VERSION = 16'h0200;
    localparam logic [15:0] VENDOR_ID = 16'hCAFE;
    localparam logic [15:0] PRODUCT_ID = 16'h4001;
    localparam logic [15:0] DEVICE_RELEASE = 16'h0100;
    localparam romByte_t MAX_PACKET0 = 8'd64;
    localparam romByte_t BULK_EP_ADDR = 8'h81;
    localparam logic [15:0] BULK_MAX_PACKET = 16'd64;

    // Full transfer length per lookup index
    localparam descLen_t descLenTable [LUT_ENTRIES] = '{
        descLen_t'(DEVICE_DESC_LEN), descLen_t'(CONFIG_TOTAL_LEN),
        descLen_t'(STRING0_LEN), descLen_t'(PRODUCT_STR_LEN)
    };

    // Descriptors follow the table back to back
    function automatic romAddr_t descOffset(input lutIdx_t idx);
        int offset;
        offset = LUT_ENTRIES;
        for (int i = 0; i < LUT_ENTRIES; i++) begin
            if (i < int'(idx)) begin
                offset += int'(descLenTable[i]);
            end
        end
        return romAddr_t'(offset);
    endfunction

    function automatic void putByte(inout romImage_t img, inout int pos, input romByte_t b);
        img[pos*8 +: 8] = b;
        pos++;
    endfunction

    // USB multi-byte fields go low byte first
    function automatic void putWord(inout romImage_t img, inout int pos, input logic [15:0] w);
        putByte(img, pos, w[7:0]);
        putByte(img, pos, w[15:8]);
    endfunction

    function automatic romImage_t buildRomImage();
        romImage_t img;
        int pos;
        img = '0;
        pos = 0;
        for (int i = 0; i < LUT_ENTRIES; i++) begin
            putByte(img, pos, romByte_t'(descOffset(lutIdx_t'(i))));
        end
        // Device descriptor
        putByte(img, pos, romByte_t'(DEVICE_DESC_LEN));
        putByte(img, pos, DESC_DEVICE);
        putWord(img, pos, USB_VERSION);
        putByte(img, pos, 8'h00);
        putByte(img, pos, 8'h00);
        putByte(img, pos, 8'h00);
        putByte(img, pos, MAX_PACKET0);
        putWord(img, pos, VENDOR_ID);
        putWord(img, pos, PRODUCT_ID);
        putWord(img, pos, DEVICE_RELEASE);
        putByte(img, pos, 8'd0);
        putByte(img, pos, 8'd1);
        putByte(img, pos, 8'd0);
        putByte(img, pos, 8'd1);
        // Configuration, self-contained bus powered at 100 mA
        putByte(img, pos, romByte_t'(CONFIG_DESC_LEN));
        putByte(img, pos, DESC_CONFIG);
        putWord(img, pos, 16'(CONFIG_TOTAL_LEN));
        putByte(img, pos, 8'd1);
        putByte(img, pos, 8'd1);
        putByte(img, pos, 8'd0);
        putByte(img, pos, 8'h80);
        putByte(img, pos, 8'd50);
        // Vendor specific interface with one endpoint
        putByte(img, pos, romByte_t'(IFACE_DESC_LEN));
        putByte(img, pos, DESC_INTERFACE);
        putByte(img, pos, 8'd0);
        putByte(img, pos, 8'd0);
        putByte(img, pos, 8'd1);
        putByte(img, pos, 8'hFF);
        putByte(img, pos, 8'h00);
        putByte(img, pos, 8'h00);
        putByte(img, pos, 8'd0);
        // Bulk IN endpoint
        putByte(img, pos, romByte_t'(EP_DESC_LEN));
        putByte(img, pos, DESC_ENDPOINT);
        putByte(img, pos, BULK_EP_ADDR);
        putByte(img, pos, 8'h02);
        putWord(img, pos, BULK_MAX_PACKET);
        putByte(img, pos, 8'd0);
        // Language list
        putByte(img, pos, romByte_t'(STRING0_LEN));
        putByte(img, pos, DESC_STRING);
        putWord(img, pos, LANG_ID);
        // Product string, first character sits in the top byte
        putByte(img, pos, romByte_t'(PRODUCT_STR_LEN));
        putByte(img, pos, DESC_STRING);
        for (int c = PRODUCT_STR_CHARS - 1; c >= 0; c--) begin
            putByte(img, pos, PRODUCT_STR[c*8 +: 8]);
            putByte(img, pos, 8'h00);
        end
        return img;
    endfunction

endpackage

// ==== descRom/descRom.sv ====
`timescale 1ns/1ps

module descRom
    import usbDescPkg::*;
(
    input  logic     clk,
    input  romAddr_t addr,
    // Valid one cycle after addr
    output romByte_t data
);

    romByte_t mem [ROM_SIZE];
    romImage_t image;

    // Lookup table in the first LUT_ENTRIES bytes, descriptors behind it
    initial begin
        image = buildRomImage();
        for (int i = 0; i < ROM_SIZE; i++) begin
            mem[i] = image[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

// ==== rtl/descFetch.sv ====
`timescale 1ns/1ps

module descFetch
    import usbDescPkg::*;
    import ep0Pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cmdValid,
    input  ep0Cmd_t   cmd,
    output logic      cmdTake,
    output logic      busy,
    output romAddr_t  romAddrOut,
    input  romByte_t  romData,
    output logic      txValid,
    output romByte_t  txData,
    output logic      txLast,
    input  logic      txReady,
    output logic      reqDone,
    output logic      reqStall,
    output ep0Event_t ep0Event
);

    typedef enum logic [2:0] {
        IDLE,
        LUT_READ,
        FIRST,
        STREAM,
        DONE
    } fetchState_t;

    fetchState_t state;
    // Address of the byte currently on romData
    romAddr_t    addrReg;
    descLen_t    remaining;
    ep0CmdKind_t kindReg;
    reqValue_t   valueReg;
    logic        beat;

    assign cmdTake = (state == IDLE) && cmdValid;
    assign busy = (state != IDLE);

    // ROM output feeds the stream directly
    assign txValid = (state == STREAM);
    assign txData = romData;
    assign txLast = txValid && (remaining == descLen_t'(1));
    assign beat = txValid && txReady;

    assign reqDone = (state == DONE);
    assign reqStall = reqDone && (kindReg == CMD_STALL);
    assign ep0Event.setAddr = reqDone && (kindReg == CMD_SET_ADDR);
    assign ep0Event.setConf = reqDone && (kindReg == CMD_SET_CONF);
    assign ep0Event.stall = reqStall;
    assign ep0Event.value = valueReg;

    always_comb begin
        case (state)
            // Lookup byte is on romData, use it as the base address
            FIRST: romAddrOut = romData[$bits(romAddr_t)-1:0];
            // Rereading the same address keeps txData stable while stalled
            STREAM: romAddrOut = (beat && !txLast) ? addrReg + 1'b1 : addrReg;
            default: romAddrOut = addrReg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cmdValid) begin
                        state <= (cmd.kind == CMD_SEND) ? LUT_READ : DONE;
                    end
                end
                LUT_READ: state <= FIRST;
                FIRST: state <= STREAM;
                STREAM: begin
                    if (beat && txLast) begin
                        state <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (cmdValid) begin
                    kindReg <= cmd.kind;
                    valueReg <= cmd.value;
                    remaining <= cmd.xferLen;
                    addrReg <= romAddr_t'(cmd.lutIndex);
                end
            end
            FIRST: addrReg <= romAddrOut;
            STREAM: begin
                if (beat) begin
                    addrReg <= romAddrOut;
                    remaining <= remaining - 1'b1;
                end
            end
            default: addrReg <= addrReg;
        endcase
    end

endmodule

// ==== rtl/ep0Regs.sv ====
`timescale 1ns/1ps

module ep0Regs
    import ep0Pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apbAddr_t  paddr,
    input  apbData_t  pwdata,
    output apbData_t  prdata,
    output logic      pready,
    output logic      pslverr,
    input  ep0Event_t ep0Event,
    output logic      enable
);

    logic        access;
    logic        mapped;
    usbAddr_t    devAddr;
    confValue_t  confValue;
    stallCount_t stallCount;

    // Zero wait state slave
    assign access = psel && penable;
    assign pready = 1'b1;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL: prdata = apbData_t'(enable);
            REG_ADDR: prdata = apbData_t'(devAddr);
            REG_CONF: prdata = apbData_t'(confValue);
            REG_STALLS: prdata = apbData_t'(stallCount);
            default: mapped = 1'b0;
        endcase
    end

    assign pslverr = access && !mapped;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            devAddr <= '0;
            confValue <= '0;
            stallCount <= '0;
        end else begin
            if (access && pwrite && paddr == REG_CTRL) begin
                enable <= pwdata[0];
            end
            if (ep0Event.setAddr) begin
                devAddr <= ep0Event.value;
            end
            if (ep0Event.setConf) begin
                confValue <= confValue_t'(ep0Event.value);
            end
            // CPU clear wins over a stall in the same cycle
            if (access && pwrite && paddr == REG_STALLS) begin
                stallCount <= '0;
            end else if (ep0Event.stall && stallCount != '1) begin
                stallCount <= stallCount + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/ep0Top.sv ====
`timescale 1ns/1ps

module ep0Top
    import usbDescPkg::*;
    import ep0Pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // SETUP channel
    input  logic         setupValid,
    input  setupPacket_t setup,
    output logic         setupReady,
    // Descriptor byte stream
    output logic         txValid,
    output romByte_t     txData,
    output logic         txLast,
    input  logic         txReady,
    output logic         reqDone,
    output logic         reqStall,
    // CPU register port
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  apbAddr_t     paddr,
    input  apbData_t     pwdata,
    output apbData_t     prdata,
    output logic         pready,
    output logic         pslverr
);

    logic      enable;
    logic      busy;
    logic      cmdValid;
    logic      cmdTake;
    ep0Cmd_t   cmd;
    romAddr_t  romAddr;
    romByte_t  romData;
    ep0Event_t ep0Event;

    setupDecoder setupDecoder_i (
        .clk        (clk),
        .reset      (reset),
        .setupValid (setupValid),
        .setup      (setup),
        .setupReady (setupReady),
        .enable     (enable),
        .busy       (busy),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .cmdTake    (cmdTake)
    );

    descFetch descFetch_i (
        .clk        (clk),
        .reset      (reset),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .cmdTake    (cmdTake),
        .busy       (busy),
        .romAddrOut (romAddr),
        .romData    (romData),
        .txValid    (txValid),
        .txData     (txData),
        .txLast     (txLast),
        .txReady    (txReady),
        .reqDone    (reqDone),
        .reqStall   (reqStall),
        .ep0Event   (ep0Event)
    );

    descRom descRom_i (
        .clk  (clk),
        .addr (romAddr),
        .data (romData)
    );

    ep0Regs ep0Regs_i (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ep0Event (ep0Event),
        .enable   (enable)
    );

endmodule

// ==== rtl/setupDecoder.sv ====
`timescale 1ns/1ps

module setupDecoder
    import usbDescPkg::*;
    import ep0Pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         setupValid,
    input  setupPacket_t setup,
    output logic         setupReady,
    input  logic         enable,
    input  logic         busy,
    output logic         cmdValid,
    output ep0Cmd_t      cmd,
    input  logic         cmdTake
);

    logic       armed;
    logic [7:0] descType;
    logic [7:0] descIndex;
    logic       lutHit;
    lutIdx_t    lutIndex;
    descLen_t   fullLen;
    ep0Cmd_t    decoded;

    // GET_DESCRIPTOR carries type in the high byte and index in the low byte
    assign descType = setup.wValue[15:8];
    assign descIndex = setup.wValue[7:0];

    always_comb begin
        lutHit = 1'b0;
        lutIndex = LUT_DEVICE;
        case (descType)
            DESC_DEVICE: begin
                lutHit = 1'b1;
            end
            DESC_CONFIG: begin
                if (descIndex == 8'd0) begin
                    lutHit = 1'b1;
                    lutIndex = LUT_CONFIG;
                end
            end
            DESC_STRING: begin
                // Language list plus the product string
                if (descIndex <= 8'd1) begin
                    lutHit = 1'b1;
                    lutIndex = LUT_STRING0 + lutIdx_t'(descIndex[0]);
                end
            end
            default: lutHit = 1'b0;
        endcase
    end

    assign fullLen = descLenTable[lutIndex];

    always_comb begin
        decoded.kind = CMD_STALL;
        decoded.lutIndex = lutIndex;
        decoded.xferLen = fullLen;
        decoded.value = setup.wValue[6:0];
        // Disabled endpoint answers everything with a stall
        if (enable) begin
            case (setup.bRequest)
                REQ_GET_DESCRIPTOR: begin
                    if (lutHit && setup.wLength != 16'd0) begin
                        decoded.kind = CMD_SEND;
                        // Host may ask for less than the full descriptor
                        if (setup.wLength < {8'd0, fullLen}) begin
                            decoded.xferLen = setup.wLength[7:0];
                        end
                    end
                end
                REQ_SET_ADDRESS: begin
                    if (setup.wValue < 16'd128) begin
                        decoded.kind = CMD_SET_ADDR;
                    end
                end
                REQ_SET_CONFIGURATION: begin
                    // Only unconfigured or the single configuration
                    if (setup.wValue <= 16'd1) begin
                        decoded.kind = CMD_SET_CONF;
                    end
                end
                default: decoded.kind = CMD_STALL;
            endcase
        end
    end

    // Not ready in the first cycle out of reset
    assign setupReady = armed && !cmdValid && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b0;
            cmdValid <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (setupValid && setupReady) begin
                cmdValid <= 1'b1;
            end else if (cmdTake) begin
                cmdValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setupValid && setupReady) begin
            cmd <= decoded;
        end
    end

endmodule

// ==== tb.f ====
+incdir+bench
common/usbDescPkg.sv
common/ep0Pkg.sv
descRom/descRom.sv
rtl/setupDecoder.sv
rtl/descFetch.sv
rtl/ep0Regs.sv
rtl/ep0Top.sv
bench/ep0Tb.sv
